//--- common/ao_periph_pkg.sv
// Always-on peripheral subsystem package
// Shared bus widths, address map, block indices and register offsets

package ao_periph_pkg;

  localparam int unsigned AddrWidth = 12;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Block number lives in the upper address nibble
  localparam int unsigned BlockMsb = 11;
  localparam int unsigned BlockLsb = 8;

  typedef enum logic [1:0] {
    SOC_CTRL_IDX  = 2'd0,
    FAST_INTR_IDX = 2'd1,
    GPIO_IDX      = 2'd2,
    TIMER_IDX     = 2'd3
  } periph_idx_e;

  localparam int unsigned NumPeriph = 4;

  // System control
  localparam logic [7:0] SocExitValidOffs = 8'h00;
  localparam logic [7:0] SocExitValueOffs = 8'h04;
  localparam logic [7:0] SocBootSelOffs   = 8'h08;

  // Fast interrupt controller
  localparam logic [7:0] FicPendingOffs = 8'h00;
  localparam logic [7:0] FicEnableOffs  = 8'h04;

  // GPIO
  localparam logic [7:0] GpioInOffs         = 8'h00;
  localparam logic [7:0] GpioOutOffs        = 8'h04;
  localparam logic [7:0] GpioOutEnOffs      = 8'h08;
  localparam logic [7:0] GpioIntrEnOffs     = 8'h0C;
  localparam logic [7:0] GpioIntrStatusOffs = 8'h10;

  // Timer
  localparam logic [7:0] TimerCountOffs   = 8'h00;
  localparam logic [7:0] TimerCompareOffs = 8'h04;
  localparam logic [7:0] TimerCtrlOffs    = 8'h08;

  localparam int unsigned NumGpioDefault  = 8;
  localparam int unsigned FastIntrDefault = 15;

endpackage

//--- logic/ao_bus_ctrl.sv
// APB slave control for the always-on peripherals
// Decodes the block number, drives selects and write strobe, muxes read data and errors
`timescale 1ns/1ps

module ao_bus_ctrl
  import ao_periph_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  addr_t                paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  data_t                pwdata_i,
  output data_t                prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  output logic [NumPeriph-1:0] sel_o,
  output logic                 we_o,
  output logic [7:0]           offs_o,
  output data_t                wdata_o,
  input  data_t                rdata_i [NumPeriph],
  input  logic [NumPeriph-1:0] hit_i
);

  logic                       setup_q;
  logic                       access;
  logic [BlockMsb-BlockLsb:0] blk;
  logic                       in_range;
  logic                       aligned;
  logic                       err;
  periph_idx_e                blk_idx;

  // Remember that the previous cycle was a setup phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel_i & ~penable_i;
    end
  end

  assign access   = psel_i & penable_i & setup_q;
  assign blk      = paddr_i[BlockMsb:BlockLsb];
  assign in_range = (blk < NumPeriph);
  assign aligned  = (paddr_i[1:0] == 2'b00);
  assign blk_idx  = periph_idx_e'(blk[1:0]);

  // One-hot block select, only for mapped blocks
  always_comb begin
    sel_o = '0;
    if (psel_i && in_range) begin
      sel_o[blk_idx] = 1'b1;
    end
  end

  assign we_o    = access & pwrite_i & in_range & aligned;
  assign offs_o  = paddr_i[7:0];
  assign wdata_o = pwdata_i;

  // Range and alignment first, then ask the block whether the offset exists
  assign err = ~in_range | ~aligned | ~hit_i[blk_idx];

  assign pready_o  = access;
  assign pslverr_o = access & err;
  assign prdata_o  = (access && !err && !pwrite_i) ? rdata_i[blk_idx] : '0;

endmodule

//--- soc_ctrl/soc_ctrl.sv
// System control registers
// Exit flag and exit value for the host, boot select readback
`timescale 1ns/1ps

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       sel_i,
  input  logic       we_i,
  input  logic [7:0] offs_i,
  input  data_t      wdata_i,
  input  logic       boot_select_i,
  output data_t      rdata_o,
  output logic       hit_o,
  output logic       exit_valid_o,
  output data_t      exit_value_o
);

  logic wr;

  assign wr = sel_i & we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else if (wr) begin
      if (offs_i == SocExitValidOffs) exit_valid_o <= wdata_i[0];
      if (offs_i == SocExitValueOffs) exit_value_o <= wdata_i;
    end
  end

  // Boot select is read only, so writes there just fall through
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (offs_i)
      SocExitValidOffs: rdata_o[0] = exit_valid_o;
      SocExitValueOffs: rdata_o    = exit_value_o;
      SocBootSelOffs:   rdata_o[0] = boot_select_i;
      default:          hit_o      = 1'b0;
    endcase
  end

endmodule

//--- logic/fast_intr_ctrl.sv
// Fast interrupt controller
// Sticky pending bits, write-one-to-clear, masked by an enable register
`timescale 1ns/1ps

module fast_intr_ctrl
  import ao_periph_pkg::*;
#(
  parameter int unsigned Width = FastIntrDefault
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             sel_i,
  input  logic             we_i,
  input  logic [7:0]       offs_i,
  input  data_t            wdata_i,
  input  logic [Width-1:0] fast_intr_i,
  output data_t            rdata_o,
  output logic             hit_o,
  output logic [Width-1:0] fast_intr_o
);

  logic [Width-1:0] pending_q;
  logic [Width-1:0] enable_q;
  logic [Width-1:0] clr;
  logic             wr;

  assign wr  = sel_i & we_i;
  assign clr = (wr && offs_i == FicPendingOffs) ? wdata_i[Width-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // New requests win over a clear in the same cycle
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (wr && offs_i == FicEnableOffs) begin
        enable_q <= wdata_i[Width-1:0];
      end
    end
  end

  assign fast_intr_o = pending_q & enable_q;

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (offs_i)
      FicPendingOffs: rdata_o[Width-1:0] = pending_q;
      FicEnableOffs:  rdata_o[Width-1:0] = enable_q;
      default:        hit_o = 1'b0;
    endcase
  end

endmodule

//--- logic/gpio_ao.sv
// Always-on GPIO
// Output and enable registers, two-flop input sync, rising-edge interrupts
`timescale 1ns/1ps

module gpio_ao
  import ao_periph_pkg::*;
#(
  parameter int unsigned NumGpio = NumGpioDefault
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               sel_i,
  input  logic               we_i,
  input  logic [7:0]         offs_i,
  input  data_t              wdata_i,
  input  logic [NumGpio-1:0] gpio_i,
  output data_t              rdata_o,
  output logic               hit_o,
  output logic [NumGpio-1:0] gpio_o,
  output logic [NumGpio-1:0] gpio_en_o,
  output logic [NumGpio-1:0] intr_gpio_o
);

  logic [NumGpio-1:0] sync_q;
  logic [NumGpio-1:0] in_q;
  logic [NumGpio-1:0] prev_q;
  logic [NumGpio-1:0] intr_en_q;
  logic [NumGpio-1:0] rise;
  logic [NumGpio-1:0] clr;
  logic               wr;

  assign wr   = sel_i & we_i;
  assign rise = in_q & ~prev_q & intr_en_q;
  assign clr  = (wr && offs_i == GpioIntrStatusOffs) ? wdata_i[NumGpio-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q      <= '0;
      in_q        <= '0;
      prev_q      <= '0;
      gpio_o      <= '0;
      gpio_en_o   <= '0;
      intr_en_q   <= '0;
      intr_gpio_o <= '0;
    end else begin
      // Second sync stage doubles as the IN register
      sync_q      <= gpio_i;
      in_q        <= sync_q;
      prev_q      <= in_q;
      intr_gpio_o <= (intr_gpio_o & ~clr) | rise;
      if (wr && offs_i == GpioOutOffs)    gpio_o    <= wdata_i[NumGpio-1:0];
      if (wr && offs_i == GpioOutEnOffs)  gpio_en_o <= wdata_i[NumGpio-1:0];
      if (wr && offs_i == GpioIntrEnOffs) intr_en_q <= wdata_i[NumGpio-1:0];
    end
  end

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (offs_i)
      GpioInOffs:         rdata_o[NumGpio-1:0] = in_q;
      GpioOutOffs:        rdata_o[NumGpio-1:0] = gpio_o;
      GpioOutEnOffs:      rdata_o[NumGpio-1:0] = gpio_en_o;
      GpioIntrEnOffs:     rdata_o[NumGpio-1:0] = intr_en_q;
      GpioIntrStatusOffs: rdata_o[NumGpio-1:0] = intr_gpio_o;
      default:            hit_o = 1'b0;
    endcase
  end

endmodule

//--- logic/timer_ao.sv
// Always-on compare timer
// Free-running counter with a level interrupt once count reaches compare
`timescale 1ns/1ps

module timer_ao
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       sel_i,
  input  logic       we_i,
  input  logic [7:0] offs_i,
  input  data_t      wdata_i,
  output data_t      rdata_o,
  output logic       hit_o,
  output logic       timer_intr_o
);

  data_t count_q;
  data_t compare_q;
  logic  enable_q;
  logic  wr;

  assign wr = sel_i & we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
    end else begin
      // Software write to COUNT takes priority over counting
      if (wr && offs_i == TimerCountOffs) begin
        count_q <= wdata_i;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && offs_i == TimerCompareOffs) begin
        compare_q <= wdata_i;
      end
      if (wr && offs_i == TimerCtrlOffs) begin
        enable_q <= wdata_i[0];
      end
    end
  end

  // Level interrupt, held while enabled and past compare
  assign timer_intr_o = enable_q & (count_q >= compare_q);

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (offs_i)
      TimerCountOffs:   rdata_o    = count_q;
      TimerCompareOffs: rdata_o    = compare_q;
      TimerCtrlOffs:    rdata_o[0] = enable_q;
      default:          hit_o      = 1'b0;
    endcase
  end

endmodule

//--- logic/ao_peripheral_subsystem.sv
// Always-on peripheral subsystem top level
// APB slave port in front of system control, fast interrupts, GPIO and timer
`timescale 1ns/1ps

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
#(
  parameter int unsigned NumGpio       = NumGpioDefault,
  parameter int unsigned FastIntrWidth = FastIntrDefault
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  addr_t                    paddr_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  data_t                    pwdata_i,
  output data_t                    prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  input  logic                     boot_select_i,
  output logic                     exit_valid_o,
  output data_t                    exit_value_o,
  input  logic [FastIntrWidth-1:0] fast_intr_i,
  output logic [FastIntrWidth-1:0] fast_intr_o,
  input  logic [NumGpio-1:0]       gpio_i,
  output logic [NumGpio-1:0]       gpio_o,
  output logic [NumGpio-1:0]       gpio_en_o,
  output logic [NumGpio-1:0]       intr_gpio_o,
  output logic                     timer_intr_o
);

  logic [NumPeriph-1:0] sel;
  logic [NumPeriph-1:0] hit;
  data_t                rdata [NumPeriph];
  logic                 we;
  logic [7:0]           offs;
  data_t                wdata;

  ao_bus_ctrl bus_ctrl_i (
    .clk_i, .rst_ni,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .sel_o(sel), .we_o(we), .offs_o(offs), .wdata_o(wdata),
    .rdata_i(rdata), .hit_i(hit)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i, .rst_ni,
    .sel_i(sel[SOC_CTRL_IDX]), .we_i(we), .offs_i(offs), .wdata_i(wdata),
    .boot_select_i,
    .rdata_o(rdata[SOC_CTRL_IDX]), .hit_o(hit[SOC_CTRL_IDX]),
    .exit_valid_o, .exit_value_o
  );

  fast_intr_ctrl #(.Width(FastIntrWidth)) fast_intr_ctrl_i (
    .clk_i, .rst_ni,
    .sel_i(sel[FAST_INTR_IDX]), .we_i(we), .offs_i(offs), .wdata_i(wdata),
    .fast_intr_i,
    .rdata_o(rdata[FAST_INTR_IDX]), .hit_o(hit[FAST_INTR_IDX]),
    .fast_intr_o
  );

  gpio_ao #(.NumGpio(NumGpio)) gpio_ao_i (
    .clk_i, .rst_ni,
    .sel_i(sel[GPIO_IDX]), .we_i(we), .offs_i(offs), .wdata_i(wdata),
    .gpio_i,
    .rdata_o(rdata[GPIO_IDX]), .hit_o(hit[GPIO_IDX]),
    .gpio_o, .gpio_en_o, .intr_gpio_o
  );

  timer_ao timer_ao_i (
    .clk_i, .rst_ni,
    .sel_i(sel[TIMER_IDX]), .we_i(we), .offs_i(offs), .wdata_i(wdata),
    .rdata_o(rdata[TIMER_IDX]), .hit_o(hit[TIMER_IDX]),
    .timer_intr_o
  );

endmodule

//--- testbench/ao_bus_chk.sv
// APB protocol assertions for the bus control
// One-hot selects, write strobe and ready only in access phases
`timescale 1ns/1ps

module ao_bus_chk
  import ao_periph_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 psel_i,
  input logic                 penable_i,
  input logic                 pready_o,
  input logic [NumPeriph-1:0] sel_o,
  input logic                 we_o
);

  int unsigned fail_cnt = 0;

  sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(sel_o))
    else begin
      fail_cnt++;
      $error("More than one block select is high");
    end

  we_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                 we_o |-> psel_i && penable_i)
    else begin
      fail_cnt++;
      $error("Write strobe high outside an access phase");
    end

  ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                    pready_o |-> psel_i && penable_i)
    else begin
      fail_cnt++;
      $error("pready high without psel and penable");
    end

endmodule

bind ao_bus_ctrl ao_bus_chk bus_chk_i (.*);

//--- testbench/ao_scoreboard.sv
// Scoreboard for the always-on peripheral subsystem
// Register model fed from the APB and pin inputs, compared with the DUT outputs
`timescale 1ns/1ps

module ao_scoreboard
  import ao_periph_pkg::*;
#(
  parameter int unsigned NumGpio = NumGpioDefault,
  parameter int unsigned FiWidth = FastIntrDefault
) (
  input logic               clk_i,
  input logic               rst_ni,
  input addr_t              paddr_i,
  input logic               psel_i,
  input logic               penable_i,
  input logic               pwrite_i,
  input data_t              pwdata_i,
  input data_t              prdata_o,
  input logic               pready_o,
  input logic               pslverr_o,
  input logic               boot_select_i,
  input logic               exit_valid_o,
  input data_t              exit_value_o,
  input logic [FiWidth-1:0] fast_intr_i,
  input logic [FiWidth-1:0] fast_intr_o,
  input logic [NumGpio-1:0] gpio_i,
  input logic [NumGpio-1:0] gpio_o,
  input logic [NumGpio-1:0] gpio_en_o,
  input logic [NumGpio-1:0] intr_gpio_o,
  input logic               timer_intr_o
);

  string       test_name = "none";
  int unsigned err_cnt   = 0;

  logic               m_exit_valid;
  data_t              m_exit_value;
  logic [FiWidth-1:0] m_pending;
  logic [FiWidth-1:0] m_fic_en;
  logic [NumGpio-1:0] m_sync;
  logic [NumGpio-1:0] m_in;
  logic [NumGpio-1:0] m_prev;
  logic [NumGpio-1:0] m_out;
  logic [NumGpio-1:0] m_out_en;
  logic [NumGpio-1:0] m_intr_en;
  logic [NumGpio-1:0] m_status;
  data_t              m_count;
  data_t              m_compare;
  logic               m_tim_en;

  // Unmapped block, misaligned, or past the last register of the block
  function automatic logic access_error(addr_t a);
    if (a[11:8] > 3 || a[1:0] != 2'b00) return 1'b1;
    case (a[11:8])
      0:       return a[7:0] > SocBootSelOffs;
      1:       return a[7:0] > FicEnableOffs;
      2:       return a[7:0] > GpioIntrStatusOffs;
      default: return a[7:0] > TimerCtrlOffs;
    endcase
  endfunction

  function automatic data_t model_read(addr_t a);
    data_t d;
    d = '0;
    case ({a[9:8], a[7:0]})
      {2'd0, SocExitValidOffs}:   d[0] = m_exit_valid;
      {2'd0, SocExitValueOffs}:   d = m_exit_value;
      {2'd0, SocBootSelOffs}:     d[0] = boot_select_i;
      {2'd1, FicPendingOffs}:     d[FiWidth-1:0] = m_pending;
      {2'd1, FicEnableOffs}:      d[FiWidth-1:0] = m_fic_en;
      {2'd2, GpioInOffs}:         d[NumGpio-1:0] = m_in;
      {2'd2, GpioOutOffs}:        d[NumGpio-1:0] = m_out;
      {2'd2, GpioOutEnOffs}:      d[NumGpio-1:0] = m_out_en;
      {2'd2, GpioIntrEnOffs}:     d[NumGpio-1:0] = m_intr_en;
      {2'd2, GpioIntrStatusOffs}: d[NumGpio-1:0] = m_status;
      {2'd3, TimerCountOffs}:     d = m_count;
      {2'd3, TimerCompareOffs}:   d = m_compare;
      {2'd3, TimerCtrlOffs}:      d[0] = m_tim_en;
      default:                    d = '0;
    endcase
    return access_error(a) ? '0 : d;
  endfunction

  // True when the access phase now in progress writes this register
  function automatic logic wr_to(int unsigned b, logic [7:0] o);
    return psel_i && penable_i && pwrite_i && !access_error(paddr_i)
           && paddr_i[11:8] == b && paddr_i[7:0] == o;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_exit_valid <= 1'b0;
      m_exit_value <= '0;
      m_pending    <= '0;
      m_fic_en     <= '0;
      m_sync       <= '0;
      m_in         <= '0;
      m_prev       <= '0;
      m_out        <= '0;
      m_out_en     <= '0;
      m_intr_en    <= '0;
      m_status     <= '0;
      m_count      <= '0;
      m_compare    <= '0;
      m_tim_en     <= 1'b0;
    end else begin
      if (wr_to(0, SocExitValidOffs)) m_exit_valid <= pwdata_i[0];
      if (wr_to(0, SocExitValueOffs)) m_exit_value <= pwdata_i;
      // Set wins over write-one-to-clear
      m_pending <= (m_pending & ~(wr_to(1, FicPendingOffs) ? pwdata_i[FiWidth-1:0] : '0))
                   | fast_intr_i;
      if (wr_to(1, FicEnableOffs)) m_fic_en <= pwdata_i[FiWidth-1:0];
      m_sync   <= gpio_i;
      m_in     <= m_sync;
      m_prev   <= m_in;
      m_status <= (m_status & ~(wr_to(2, GpioIntrStatusOffs) ? pwdata_i[NumGpio-1:0] : '0))
                  | (m_in & ~m_prev & m_intr_en);
      if (wr_to(2, GpioOutOffs)) m_out <= pwdata_i[NumGpio-1:0];
      if (wr_to(2, GpioOutEnOffs)) m_out_en <= pwdata_i[NumGpio-1:0];
      if (wr_to(2, GpioIntrEnOffs)) m_intr_en <= pwdata_i[NumGpio-1:0];
      if (wr_to(3, TimerCountOffs)) m_count <= pwdata_i;
      else if (m_tim_en) m_count <= m_count + 1;
      if (wr_to(3, TimerCompareOffs)) m_compare <= pwdata_i;
      if (wr_to(3, TimerCtrlOffs)) m_tim_en <= pwdata_i[0];
    end
  end

  task automatic compare_value(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Outputs have settled by mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      compare_value("exit_valid_o", m_exit_valid, exit_valid_o);
      compare_value("exit_value_o", m_exit_value, exit_value_o);
      compare_value("fast_intr_o", m_pending & m_fic_en, fast_intr_o);
      compare_value("gpio_o", m_out, gpio_o);
      compare_value("gpio_en_o", m_out_en, gpio_en_o);
      compare_value("intr_gpio_o", m_status, intr_gpio_o);
      compare_value("timer_intr_o", m_tim_en && m_count >= m_compare, timer_intr_o);
      compare_value("pready_o", psel_i & penable_i, pready_o);
      compare_value("pslverr_o", psel_i && penable_i && access_error(paddr_i), pslverr_o);
      if (psel_i && penable_i && !pwrite_i) begin
        compare_value("prdata_o", model_read(paddr_i), prdata_o);
      end
    end
  end

endmodule

//--- testbench/tb_ao_peripheral_subsystem.sv
// Testbench for the always-on peripheral subsystem
// Seeded random APB traffic and pin stimulus, compared by the scoreboard
`timescale 1ns/1ps

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  localparam int unsigned NumGpio = NumGpioDefault;
  localparam int unsigned FiWidth = FastIntrDefault;
  localparam int unsigned Timeout = 200;

  logic               clk_i;
  logic               rst_ni;
  addr_t              paddr_i;
  logic               psel_i;
  logic               penable_i;
  logic               pwrite_i;
  data_t              pwdata_i;
  data_t              prdata_o;
  logic               pready_o;
  logic               pslverr_o;
  logic               boot_select_i;
  logic               exit_valid_o;
  data_t              exit_value_o;
  logic [FiWidth-1:0] fast_intr_i;
  logic [FiWidth-1:0] fast_intr_o;
  logic [NumGpio-1:0] gpio_i;
  logic [NumGpio-1:0] gpio_o;
  logic [NumGpio-1:0] gpio_en_o;
  logic [NumGpio-1:0] intr_gpio_o;
  logic               timer_intr_o;

  integer      seed;
  int unsigned tb_errs;
  int unsigned total;
  int unsigned wait_cnt;
  int unsigned mode;
  data_t       rd;
  data_t       cmp;
  logic        er;
  logic        wr_bit;
  addr_t       addr;

  ao_peripheral_subsystem #(.NumGpio(NumGpio), .FastIntrWidth(FiWidth)) dut_i (.*);
  ao_scoreboard #(.NumGpio(NumGpio), .FiWidth(FiWidth)) sb_i (.*);

  always #50 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // One APB transfer with a setup and an access phase
  task automatic bus_access(input addr_t a, input logic wr, input data_t wdata,
                            output data_t rdata, output logic err);
    int unsigned cnt;
    cnt = 0;
    @(posedge clk_i);
    #1;
    paddr_i  = a;
    pwrite_i = wr;
    pwdata_i = wdata;
    psel_i   = 1'b1;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    while (!pready_o && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!pready_o) begin
      abort_run("APB transfer hung, pready never came");
    end else begin
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge clk_i);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
    end
  endtask

  task automatic read_all_regs();
    for (int b = 0; b < NumPeriph; b++) begin
      for (int o = 0; o <= 16; o += 4) begin
        bus_access(addr_t'(b * 256 + o), 1'b0, '0, rd, er);
      end
    end
  endtask

  initial begin
    seed          = 32'hcc32aa7d;
    tb_errs       = 0;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    paddr_i       = '0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    pwdata_i      = '0;
    boot_select_i = $random(seed);
    fast_intr_i   = '0;
    gpio_i        = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    sb_i.test_name = "reset";
    read_all_regs();

    // Writes to the boot select offset must not stick
    sb_i.test_name = "soc_ctrl";
    repeat (6) begin
      boot_select_i = ~boot_select_i;
      for (int o = 0; o < 12; o += 4) bus_access(addr_t'(o), 1'b1, $random(seed), rd, er);
      for (int o = 0; o < 12; o += 4) bus_access(addr_t'(o), 1'b0, '0, rd, er);
    end

    sb_i.test_name = "fast_intr";
    bus_access(12'h104, 1'b1, $random(seed), rd, er);
    repeat (12) begin
      fast_intr_i = $random(seed) & $random(seed);
      bus_access(12'h100, 1'b0, '0, rd, er);
      fast_intr_i = $random(seed) & $random(seed) & $random(seed);
      bus_access(12'h100, 1'b1, $random(seed), rd, er);
      fast_intr_i = '0;
      bus_access(12'h100, 1'b0, '0, rd, er);
    end

    sb_i.test_name = "gpio";
    bus_access(12'h20C, 1'b1, $random(seed), rd, er);
    repeat (12) begin
      gpio_i = $random(seed);
      bus_access(12'h204, 1'b1, $random(seed), rd, er);
      bus_access(12'h208, 1'b1, $random(seed), rd, er);
      bus_access(12'h200, 1'b0, '0, rd, er);
      bus_access(12'h210, 1'b0, '0, rd, er);
      bus_access(12'h210, 1'b1, $random(seed), rd, er);
    end

    sb_i.test_name = "timer";
    cmp = ({$random(seed)} % 64) + 4;
    bus_access(12'h300, 1'b1, '0, rd, er);
    bus_access(12'h304, 1'b1, cmp, rd, er);
    bus_access(12'h308, 1'b1, 32'h1, rd, er);
    wait_cnt = 0;
    while (!timer_intr_o && wait_cnt < Timeout) begin
      @(posedge clk_i);
      #1;
      wait_cnt++;
    end
    if (!timer_intr_o) begin
      abort_run("Timer interrupt never rose after enabling the timer");
    end else begin
      bus_access(12'h300, 1'b0, '0, rd, er);
      if (rd < cmp) begin
        tb_errs++;
        $display("Mismatch %s count: expected at least %h actual %h", sb_i.test_name, cmp, rd);
      end
      bus_access(12'h308, 1'b1, '0, rd, er);
      if (timer_intr_o !== 1'b0) begin
        tb_errs++;
        $display("Mismatch %s timer_intr_o: expected 0 actual %b", sb_i.test_name, timer_intr_o);
      end

      // Mode 0 out of range, 1 misaligned, 2 unused offset
      sb_i.test_name = "errors";
      repeat (24) begin
        mode = {$random(seed)} % 3;
        addr = $random(seed);
        case (mode)
          0: begin
            addr[11:8] = 4'd4 + 4'({$random(seed)} % 12);
            addr[7:0]  = 8'(({$random(seed)} % 5) * 4);
          end
          1: addr[1:0] = 2'd1 + 2'({$random(seed)} % 3);
          default: addr[7:0] = 8'h14 + 8'(({$random(seed)} % 59) * 4);
        endcase
        if (mode != 0) addr[11:10] = 2'b00;
        wr_bit = $random(seed);
        bus_access(addr, wr_bit, $random(seed), rd, er);
      end
      read_all_regs();

      total = tb_errs + sb_i.err_cnt + dut_i.bus_ctrl_i.bus_chk_i.fail_cnt;
      $display("Done: %0d scoreboard errors, %0d testbench errors, %0d assertion errors",
               sb_i.err_cnt, tb_errs, dut_i.bus_ctrl_i.bus_chk_i.fail_cnt);
      if (total == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

//--- filelist.f
common/ao_periph_pkg.sv
logic/ao_bus_ctrl.sv
soc_ctrl/soc_ctrl.sv
logic/fast_intr_ctrl.sv
logic/gpio_ao.sv
logic/timer_ao.sv
logic/ao_peripheral_subsystem.sv
testbench/ao_bus_chk.sv
testbench/ao_scoreboard.sv
testbench/tb_ao_peripheral_subsystem.sv

//--- Bender.yml
package:
  name: ao_peripheral_subsystem

sources:
  - common/ao_periph_pkg.sv
  - logic/ao_bus_ctrl.sv
  - soc_ctrl/soc_ctrl.sv
  - logic/fast_intr_ctrl.sv
  - logic/gpio_ao.sv
  - logic/timer_ao.sv
  - logic/ao_peripheral_subsystem.sv
  - target: test
    files:
      - testbench/ao_bus_chk.sv
      - testbench/ao_scoreboard.sv
      - testbench/tb_ao_peripheral_subsystem.sv
